// File: tb.f
verilog/axi_proto_pkg.sv
verilog/bridge_ctrl_pkg.sv
verilog/axi_req_slice.sv
verilog/beat_addr_gen.sv
verilog/resp_tracker_fifo.sv
verilog/resp_merger.sv
verilog/burst_unroll_ctrl.sv
verilog/axi2axil_bridge.sv
tb/tb_axi2axil.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi2axil -f tb.f -o sim_tb_axi2axil

./obj_dir/sim_tb_axi2axil > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
grep -q "All tests passed" sim.log

// File: tb/tb_axi2axil.sv
module tb_axi2axil import axi_proto_pkg::*, bridge_ctrl_pkg::*;;

  localparam int max_outstanding = 4;
  localparam logic [31:0] rd_pattern = 32'h5a3c_c3a5;

  logic clk;
  logic reset;
  logic [15:0] aw_addr, ar_addr, axil_aw_addr, axil_ar_addr;
  logic [3:0]  aw_id, ar_id, b_id, r_id;
  logic [7:0]  aw_len, ar_len;
  logic [2:0]  aw_size, ar_size, aw_prot, ar_prot, axil_aw_prot, axil_ar_prot;
  axi_burst_t  aw_burst, ar_burst;
  logic        aw_valid, aw_ready, ar_valid, ar_ready;
  logic [31:0] w_data, axil_w_data, r_data, axil_r_data;
  logic [3:0]  w_strb, axil_w_strb;
  logic        w_last, w_valid, w_ready, b_valid, b_ready, r_last, r_valid, r_ready;
  axi_resp_t   b_resp, r_resp, axil_b_resp, axil_r_resp;
  logic        axil_aw_valid, axil_aw_ready, axil_w_valid, axil_w_ready;
  logic        axil_b_valid, axil_b_ready, axil_ar_valid, axil_ar_ready;
  logic        axil_r_valid, axil_r_ready;
  ctrl_state_t wr_state, rd_state;

  // --------------------
  // Stimulus, scoreboard and target model state
  logic [31:0] lfsr = 32'h0df6b477;
  int          errors = 0;
  string       test_name = "reset";
  bit          started = 0;
  bit          rand_ready = 0;
  int          wr_outstanding = 0;
  int          rd_outstanding = 0;
  int          m_w_cnt = 0;
  // AXI4 requests, packed as {prot, addr, id, len, size, burst}
  logic [35:0] aw_req_q[$];
  logic [35:0] ar_req_q[$];
  // Write beats as {last, strb, data}
  logic [36:0] w_q[$];
  // Lite requests as {prot, addr}
  logic [18:0] exp_aw_addr[$];
  logic [18:0] exp_ar_addr[$];
  // B as {id, resp}, R as {id, last, resp, data}
  logic [5:0]  exp_b[$];
  logic [38:0] exp_r[$];
  // Lite target queues
  logic [15:0] m_aw_addr[$];
  logic [15:0] m_ar_addr[$];
  logic [1:0]  m_b[$];
  // Response code per address, picked once
  logic [1:0]  err_code[logic [15:0]];

  axi2axil_bridge #(
    .addr_width(16), .data_width(32), .id_width(4), .max_outstanding(max_outstanding)
  ) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else begin
      errors++;
      $display("error %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // --------------------
  // Expected beats from the AXI burst rules
  task automatic queue_burst(input bit is_write, input logic [15:0] addr, input logic [3:0] id,
                             input logic [7:0] len, input logic [2:0] size,
                             input logic [1:0] burst);
    int wrap_bytes;
    int base;
    int ia;
    logic [15:0] a;
    logic [31:0] d;
    logic [3:0] s;
    logic [2:0] prot;
    logic [2:0] pick;
    logic [1:0] merged;
    merged = 2'b00;
    ia = int'(addr);
    wrap_bytes = (int'(len) + 1) << size;
    base = (ia / wrap_bytes) * wrap_bytes;
    prot = 3'(rand_bits(3));
    started = 1;
    if (is_write) begin
      aw_req_q.push_back({prot, addr, id, len, size, burst});
    end else begin
      ar_req_q.push_back({prot, addr, id, len, size, burst});
    end
    for (int i = 0; i <= int'(len); i++) begin
      case (burst)
        2'b00:   a = addr;
        2'b01:   a = 16'(ia + (i << size));
        // Aligned window of (len+1) beats, offset wraps inside it
        default: a = 16'(base + ((ia - base + (i << size)) % wrap_bytes));
      endcase
      if (!err_code.exists(a)) begin
        pick = 3'(rand_bits(3));
        err_code[a] = (pick == 0) ? 2'b10 : (pick == 1) ? 2'b11 : 2'b00;
      end
      if (is_write) begin
        d = rand_bits(32);
        s = 4'(rand_bits(4));
        w_q.push_back({i == int'(len), s, d});
        exp_aw_addr.push_back({prot, a});
        if (err_code[a] != 2'b00) begin
          merged = err_code[a];
        end
      end else begin
        exp_ar_addr.push_back({prot, a});
        exp_r.push_back({id, i == int'(len), err_code[a], {16'h0, a} ^ rd_pattern});
      end
    end
    if (is_write) begin
      exp_b.push_back({id, merged});
    end
  endtask

  // --------------------
  // Bus drive on the falling edge, handshakes sampled once settled
  task automatic drive_bus();
    aw_valid = aw_req_q.size() != 0;
    if (aw_valid) begin
      {aw_prot, aw_addr, aw_id, aw_len, aw_size} = aw_req_q[0][35:2];
      aw_burst = axi_burst_t'(aw_req_q[0][1:0]);
    end
    ar_valid = ar_req_q.size() != 0;
    if (ar_valid) begin
      {ar_prot, ar_addr, ar_id, ar_len, ar_size} = ar_req_q[0][35:2];
      ar_burst = axi_burst_t'(ar_req_q[0][1:0]);
    end
    w_valid = w_q.size() != 0;
    if (w_valid) begin
      {w_last, w_strb, w_data} = w_q[0];
    end
    axil_b_valid = m_b.size() != 0;
    if (axil_b_valid) begin
      axil_b_resp = axi_resp_t'(m_b[0]);
    end
    axil_r_valid = m_ar_addr.size() != 0;
    if (axil_r_valid) begin
      axil_r_data = {16'h0, m_ar_addr[0]} ^ rd_pattern;
      axil_r_resp = axi_resp_t'(err_code.exists(m_ar_addr[0]) ?
                                err_code[m_ar_addr[0]] : 2'b00);
    end
    axil_aw_ready = rand_ready ? (rand_bits(2) != 0) : 1'b1;
    axil_w_ready  = rand_ready ? (rand_bits(2) != 0) : 1'b1;
    axil_ar_ready = rand_ready ? (rand_bits(2) != 0) : 1'b1;
    b_ready       = rand_ready ? (rand_bits(2) != 0) : 1'b1;
    r_ready       = rand_ready ? (rand_bits(2) != 0) : 1'b1;
  endtask

  task automatic sample_bus();
    if (aw_valid && aw_ready) void'(aw_req_q.pop_front());
    if (ar_valid && ar_ready) void'(ar_req_q.pop_front());
    if (axil_b_valid && axil_b_ready) begin
      void'(m_b.pop_front());
      wr_outstanding--;
    end
    if (axil_r_valid && axil_r_ready) begin
      void'(m_ar_addr.pop_front());
      rd_outstanding--;
    end
    if (axil_aw_valid && axil_aw_ready) begin
      if (exp_aw_addr.size() == 0) begin
        errors++;
        $display("Lite write request with no burst beat left in test %s", test_name);
      end else begin
        check_value("axil aw prot addr", exp_aw_addr.pop_front(), {axil_aw_prot, axil_aw_addr});
      end
      m_aw_addr.push_back(axil_aw_addr);
      wr_outstanding++;
    end
    if (w_valid && w_ready) begin
      check_value("axil w data", w_q[0][31:0], axil_w_data);
      check_value("axil w strb", w_q[0][35:32], axil_w_strb);
      void'(w_q.pop_front());
    end
    // Lite side of write data, counted where the target sees it
    if (axil_w_valid && axil_w_ready) begin
      m_w_cnt++;
    end
    // Target answers once address and data of a beat are both in
    while (m_aw_addr.size() != 0 && m_w_cnt > 0) begin
      m_b.push_back(err_code.exists(m_aw_addr[0]) ? err_code[m_aw_addr[0]] : 2'b00);
      void'(m_aw_addr.pop_front());
      m_w_cnt--;
    end
    if (axil_ar_valid && axil_ar_ready) begin
      if (exp_ar_addr.size() == 0) begin
        errors++;
        $display("Lite read request with no burst beat left in test %s", test_name);
      end else begin
        check_value("axil ar prot addr", exp_ar_addr.pop_front(), {axil_ar_prot, axil_ar_addr});
      end
      m_ar_addr.push_back(axil_ar_addr);
      rd_outstanding++;
    end
    if (b_valid && b_ready) begin
      if (exp_b.size() == 0) begin
        errors++;
        $display("write response with no burst waiting in test %s", test_name);
      end else begin
        check_value("b id resp", exp_b.pop_front(), {b_id, b_resp});
      end
    end
    if (r_valid && r_ready) begin
      if (exp_r.size() == 0) begin
        errors++;
        $display("read beat with no burst waiting in test %s", test_name);
      end else begin
        check_value("r id last resp data", exp_r.pop_front(), {r_id, r_last, r_resp, r_data});
      end
    end
  endtask

  initial begin
    aw_valid = 0; aw_addr = '0; aw_id = '0; aw_len = '0; aw_size = '0;
    aw_burst = burst_incr; aw_prot = '0;
    ar_valid = 0; ar_addr = '0; ar_id = '0; ar_len = '0; ar_size = '0;
    ar_burst = burst_incr; ar_prot = '0;
    w_valid = 0; w_data = '0; w_strb = '1; w_last = 0;
    b_ready = 0; r_ready = 0;
    axil_aw_ready = 0; axil_w_ready = 0; axil_ar_ready = 0;
    axil_b_valid = 0; axil_b_resp = resp_okay;
    axil_r_valid = 0; axil_r_data = '0; axil_r_resp = resp_okay;
    forever begin
      @(negedge clk);
      drive_bus();
      #10;
      if (!reset) sample_bus();
    end
  end

  // --------------------
  // Protocol checks
  a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
    !started |-> !axil_aw_valid && !axil_ar_valid && !b_valid && !r_valid &&
                 wr_state == st_idle && rd_state == st_idle)
    else begin
      errors++;
      $display("bridge left idle before any request was sent");
    end

  // A beat waiting on the Lite target keeps its controller issuing
  a_wr_state_issue: assert property (@(posedge clk) disable iff (reset)
    axil_aw_valid && !axil_aw_ready |=> wr_state == st_issue)
    else begin
      errors++;
      $display("error %s wr_state: expected %0d actual %0d", test_name, st_issue,
               $sampled(wr_state));
    end

  a_rd_state_issue: assert property (@(posedge clk) disable iff (reset)
    axil_ar_valid && !axil_ar_ready |=> rd_state == st_issue)
    else begin
      errors++;
      $display("error %s rd_state: expected %0d actual %0d", test_name, st_issue,
               $sampled(rd_state));
    end

  a_wr_limit: assert property (@(posedge clk) disable iff (reset)
    wr_outstanding <= max_outstanding)
    else begin
      errors++;
      $display("more Lite writes outstanding than the tracker depth");
    end

  a_rd_limit: assert property (@(posedge clk) disable iff (reset)
    rd_outstanding <= max_outstanding)
    else begin
      errors++;
      $display("more Lite reads outstanding than the tracker depth");
    end

  function automatic bit drained();
    return aw_req_q.size() == 0 && ar_req_q.size() == 0 && w_q.size() == 0 &&
           exp_b.size() == 0 && exp_r.size() == 0 && m_b.size() == 0 &&
           m_ar_addr.size() == 0 && exp_aw_addr.size() == 0 && exp_ar_addr.size() == 0 &&
           m_aw_addr.size() == 0 && m_w_cnt == 0;
  endfunction

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (!drained() && cycles < 5000) begin
      @(posedge clk);
      cycles++;
    end
    if (!drained()) begin
      errors++;
      $display("timeout: traffic did not drain in test %s", test_name);
    end
  endtask

  task automatic random_burst(input bit is_write);
    logic [1:0] burst;
    logic [2:0] size;
    logic [7:0] len;
    logic [15:0] addr;
    burst = 2'(rand_bits(2) % 3);
    size  = 3'(rand_bits(2) % 3);
    len   = (burst == 2'b10) ? ((8'd2 << (rand_bits(2) % 3)) - 8'd1) : 8'(rand_bits(3));
    addr  = 16'(rand_bits(15)) & ~((16'd1 << size) - 16'd1);
    queue_burst(is_write, addr, 4'(rand_bits(4)), len, size, burst);
  endtask

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // Idle stretch with nothing sent
    repeat (8) @(posedge clk);

    test_name = "incr_write";
    queue_burst(1, 16'h0100, 4'd3, 8'd3, 3'd2, 2'b01);
    wait_drain();

    // SLVERR then DECERR inside one burst, then a clean burst
    test_name = "merged_resp";
    err_code[16'h0700] = 2'b10;
    err_code[16'h0704] = 2'b00;
    err_code[16'h0708] = 2'b11;
    err_code[16'h070c] = 2'b00;
    err_code[16'h0800] = 2'b00;
    err_code[16'h0804] = 2'b00;
    queue_burst(1, 16'h0700, 4'd2, 8'd3, 3'd2, 2'b01);
    queue_burst(1, 16'h0800, 4'd4, 8'd1, 3'd2, 2'b01);
    wait_drain();

    test_name = "wrap_fixed";
    queue_burst(1, 16'h0208, 4'd5, 8'd3, 3'd2, 2'b10);
    queue_burst(1, 16'h0300, 4'd6, 8'd2, 3'd2, 2'b00);
    queue_burst(0, 16'h0416, 4'd7, 8'd7, 3'd1, 2'b10);
    queue_burst(0, 16'h0520, 4'd8, 8'd3, 3'd2, 2'b00);
    wait_drain();

    test_name = "incr_read";
    queue_burst(0, 16'h0600, 4'd9, 8'd7, 3'd2, 2'b01);
    wait_drain();

    test_name = "backpressure";
    rand_ready = 1;
    for (int k = 0; k < 16; k++) begin
      random_burst(1);
      random_burst(0);
    end
    wait_drain();

    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verilog/axi2axil_bridge.sv
module axi2axil_bridge import axi_proto_pkg::*, bridge_ctrl_pkg::*; #(
  parameter int addr_width      = 16,
  parameter int data_width      = 32,
  parameter int id_width        = 4,
  parameter int max_outstanding = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  // AXI4 write address
  input  logic [addr_width-1:0]     aw_addr,
  input  logic [id_width-1:0]       aw_id,
  input  logic [axi_len_width-1:0]  aw_len,
  input  logic [axi_size_width-1:0] aw_size,
  input  axi_burst_t                aw_burst,
  input  logic [axi_prot_width-1:0] aw_prot,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  // AXI4 write data
  input  logic [data_width-1:0]     w_data,
  input  logic [data_width/8-1:0]   w_strb,
  input  logic                      w_last,
  input  logic                      w_valid,
  output logic                      w_ready,
  // AXI4 write response
  output logic [id_width-1:0]       b_id,
  output axi_resp_t                 b_resp,
  output logic                      b_valid,
  input  logic                      b_ready,
  // AXI4 read address
  input  logic [addr_width-1:0]     ar_addr,
  input  logic [id_width-1:0]       ar_id,
  input  logic [axi_len_width-1:0]  ar_len,
  input  logic [axi_size_width-1:0] ar_size,
  input  axi_burst_t                ar_burst,
  input  logic [axi_prot_width-1:0] ar_prot,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  // AXI4 read data
  output logic [id_width-1:0]       r_id,
  output logic [data_width-1:0]     r_data,
  output axi_resp_t                 r_resp,
  output logic                      r_last,
  output logic                      r_valid,
  input  logic                      r_ready,
  // AXI4-Lite write channels
  output logic [addr_width-1:0]     axil_aw_addr,
  output logic [axi_prot_width-1:0] axil_aw_prot,
  output logic                      axil_aw_valid,
  input  logic                      axil_aw_ready,
  output logic [data_width-1:0]     axil_w_data,
  output logic [data_width/8-1:0]   axil_w_strb,
  output logic                      axil_w_valid,
  input  logic                      axil_w_ready,
  input  axi_resp_t                 axil_b_resp,
  input  logic                      axil_b_valid,
  output logic                      axil_b_ready,
  // AXI4-Lite read channels
  output logic [addr_width-1:0]     axil_ar_addr,
  output logic [axi_prot_width-1:0] axil_ar_prot,
  output logic                      axil_ar_valid,
  input  logic                      axil_ar_ready,
  input  logic [data_width-1:0]     axil_r_data,
  input  axi_resp_t                 axil_r_resp,
  input  logic                      axil_r_valid,
  output logic                      axil_r_ready,
  // Controller states for debug
  output ctrl_state_t               wr_state,
  output ctrl_state_t               rd_state
);

  if (addr_width < 12 || max_outstanding < 2 || !(data_width == 32 || data_width == 64))
  begin : gen_bad_params
    $error("axi2axil_bridge parameters out of range");
  end

  // --------------------
  // Write channel
  logic                      wr_hold_valid;
  logic [addr_width-1:0]     wr_hold_addr;
  logic [id_width-1:0]       wr_hold_id;
  logic [axi_len_width-1:0]  wr_hold_len;
  logic [axi_size_width-1:0] wr_hold_size;
  axi_burst_t                wr_hold_burst;
  logic                      wr_pop;
  logic                      wr_is_last;
  logic                      wr_beat_fire;
  logic                      wr_room;
  logic                      wr_head_valid;
  logic [id_width-1:0]       wr_head_id;
  logic                      wr_head_last;
  logic                      wr_resp_pop;

  // Write data is beat-for-beat, the Lite target needs no last
  assign axil_w_data  = w_data;
  assign axil_w_strb  = w_strb;
  assign axil_w_valid = w_valid;
  assign w_ready      = axil_w_ready;

  axi_req_slice #(.addr_width(addr_width), .id_width(id_width)) wr_slice_i (
    .clk, .reset,
    .req_addr(aw_addr), .req_id(aw_id), .req_len(aw_len), .req_size(aw_size),
    .req_burst(aw_burst), .req_prot(aw_prot), .req_valid(aw_valid), .req_ready(aw_ready),
    .pop(wr_pop), .hold_valid(wr_hold_valid), .hold_addr(wr_hold_addr),
    .hold_id(wr_hold_id), .hold_len(wr_hold_len), .hold_size(wr_hold_size),
    .hold_burst(wr_hold_burst), .hold_prot(axil_aw_prot)
  );

  beat_addr_gen #(.addr_width(addr_width)) wr_addr_i (
    .clk, .reset,
    .start_addr(wr_hold_addr), .len(wr_hold_len), .size(wr_hold_size),
    .burst(wr_hold_burst), .beat_fire(wr_beat_fire), .clear(wr_pop),
    .beat_addr(axil_aw_addr), .is_last(wr_is_last)
  );

  burst_unroll_ctrl #(.is_read(1'b0)) wr_ctrl_i (
    .clk, .reset,
    .hold_valid(wr_hold_valid), .is_last(wr_is_last), .room(wr_room),
    .axil_req_valid(axil_aw_valid), .axil_req_ready(axil_aw_ready),
    .beat_fire(wr_beat_fire), .pop(wr_pop), .state(wr_state)
  );

  resp_tracker_fifo #(.id_width(id_width), .max_outstanding(max_outstanding)) wr_track_i (
    .clk, .reset,
    .push(wr_beat_fire), .push_id(wr_hold_id), .push_last(wr_is_last), .room(wr_room),
    .pop(wr_resp_pop), .head_valid(wr_head_valid), .head_id(wr_head_id),
    .head_last(wr_head_last)
  );

  // B has no data or last
  resp_merger #(.id_width(id_width), .data_width(data_width), .is_read(1'b0)) wr_merge_i (
    .clk, .reset,
    .head_valid(wr_head_valid), .head_id(wr_head_id), .head_last(wr_head_last),
    .pop(wr_resp_pop), .axil_resp(axil_b_resp), .axil_data('0),
    .axil_resp_valid(axil_b_valid), .axil_resp_ready(axil_b_ready),
    .out_id(b_id), .out_resp(b_resp), .out_data(), .out_last(), .out_valid(b_valid),
    .out_ready(b_ready)
  );

  // --------------------
  // Read channel
  logic                      rd_hold_valid;
  logic [addr_width-1:0]     rd_hold_addr;
  logic [id_width-1:0]       rd_hold_id;
  logic [axi_len_width-1:0]  rd_hold_len;
  logic [axi_size_width-1:0] rd_hold_size;
  axi_burst_t                rd_hold_burst;
  logic                      rd_pop;
  logic                      rd_is_last;
  logic                      rd_beat_fire;
  logic                      rd_room;
  logic                      rd_head_valid;
  logic [id_width-1:0]       rd_head_id;
  logic                      rd_head_last;
  logic                      rd_resp_pop;

  axi_req_slice #(.addr_width(addr_width), .id_width(id_width)) rd_slice_i (
    .clk, .reset,
    .req_addr(ar_addr), .req_id(ar_id), .req_len(ar_len), .req_size(ar_size),
    .req_burst(ar_burst), .req_prot(ar_prot), .req_valid(ar_valid), .req_ready(ar_ready),
    .pop(rd_pop), .hold_valid(rd_hold_valid), .hold_addr(rd_hold_addr),
    .hold_id(rd_hold_id), .hold_len(rd_hold_len), .hold_size(rd_hold_size),
    .hold_burst(rd_hold_burst), .hold_prot(axil_ar_prot)
  );

  beat_addr_gen #(.addr_width(addr_width)) rd_addr_i (
    .clk, .reset,
    .start_addr(rd_hold_addr), .len(rd_hold_len), .size(rd_hold_size),
    .burst(rd_hold_burst), .beat_fire(rd_beat_fire), .clear(rd_pop),
    .beat_addr(axil_ar_addr), .is_last(rd_is_last)
  );

  burst_unroll_ctrl #(.is_read(1'b1)) rd_ctrl_i (
    .clk, .reset,
    .hold_valid(rd_hold_valid), .is_last(rd_is_last), .room(rd_room),
    .axil_req_valid(axil_ar_valid), .axil_req_ready(axil_ar_ready),
    .beat_fire(rd_beat_fire), .pop(rd_pop), .state(rd_state)
  );

  resp_tracker_fifo #(.id_width(id_width), .max_outstanding(max_outstanding)) rd_track_i (
    .clk, .reset,
    .push(rd_beat_fire), .push_id(rd_hold_id), .push_last(rd_is_last), .room(rd_room),
    .pop(rd_resp_pop), .head_valid(rd_head_valid), .head_id(rd_head_id),
    .head_last(rd_head_last)
  );

  resp_merger #(.id_width(id_width), .data_width(data_width), .is_read(1'b1)) rd_merge_i (
    .clk, .reset,
    .head_valid(rd_head_valid), .head_id(rd_head_id), .head_last(rd_head_last),
    .pop(rd_resp_pop), .axil_resp(axil_r_resp), .axil_data(axil_r_data),
    .axil_resp_valid(axil_r_valid), .axil_resp_ready(axil_r_ready),
    .out_id(r_id), .out_resp(r_resp), .out_data(r_data), .out_last(r_last),
    .out_valid(r_valid), .out_ready(r_ready)
  );

endmodule

// File: verilog/burst_unroll_ctrl.sv
module burst_unroll_ctrl import bridge_ctrl_pkg::*; #(
  parameter bit is_read = 1'b0
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        hold_valid,
  input  logic        is_last,
  input  logic        room,
  output logic        axil_req_valid,
  input  logic        axil_req_ready,
  output logic        beat_fire,
  output logic        pop,
  output ctrl_state_t state
);

  ctrl_state_t state_next;

  // --------------------
  // Beat issue
  // Valid follows the held burst directly so the first beat
  // leaves the cycle after capture; room only drops on a push,
  // so a raised valid stays up until it is taken
  assign axil_req_valid = hold_valid && room;
  assign beat_fire      = axil_req_valid && axil_req_ready;

  // Retire the burst on the last beat handshake
  assign pop = beat_fire && is_last;

  // --------------------
  // State register
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (hold_valid) begin
          state_next = room ? st_issue : st_stall;
        end
      end
      st_issue: begin
        if (pop || !hold_valid) begin
          state_next = st_idle;
        end else if (!room) begin
          state_next = st_stall;
        end
      end
      st_stall: begin
        // Tracker drained an entry
        if (pop || !hold_valid) begin
          state_next = st_idle;
        end else if (room) begin
          state_next = st_issue;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  // Valid must stay up until accepted
  a_valid_held: assert property (@(posedge clk) disable iff (reset)
    axil_req_valid && !axil_req_ready |=> axil_req_valid)
    else $error("%s burst controller dropped valid before handshake",
                is_read ? "read" : "write");

endmodule

// File: verilog/resp_merger.sv
module resp_merger import axi_proto_pkg::*; #(
  parameter int id_width   = 4,
  parameter int data_width = 32,
  parameter bit is_read    = 1'b0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  head_valid,
  input  logic [id_width-1:0]   head_id,
  input  logic                  head_last,
  output logic                  pop,
  input  axi_resp_t             axil_resp,
  input  logic [data_width-1:0] axil_data,
  input  logic                  axil_resp_valid,
  output logic                  axil_resp_ready,
  output logic [id_width-1:0]   out_id,
  output axi_resp_t             out_resp,
  output logic [data_width-1:0] out_data,
  output logic                  out_last,
  output logic                  out_valid,
  input  logic                  out_ready
);

  // ID and last come from the tracker head
  assign out_id   = head_id;
  assign out_last = head_last;
  assign out_data = axil_data;
  assign pop      = axil_resp_valid && axil_resp_ready;

  if (is_read) begin : gen_read
    // One R beat per Lite response
    assign out_valid       = axil_resp_valid;
    assign out_resp        = axil_resp;
    assign axil_resp_ready = out_ready;
  end else begin : gen_write
    axi_resp_t merged_resp;

    // Latest non-OKAY code of the burst, cleared once B goes out
    always_ff @(posedge clk) begin
      if (reset || (out_valid && out_ready)) begin
        merged_resp <= resp_okay;
      end else if (pop && axil_resp != resp_okay) begin
        merged_resp <= axil_resp;
      end
    end

    // Middle beats absorbed here, only the last beat waits on b_ready
    assign out_valid       = head_last && axil_resp_valid;
    assign out_resp        = (axil_resp != resp_okay) ? axil_resp : merged_resp;
    assign axil_resp_ready = !head_last || out_ready;
  end

  // Every Lite response must match a tracked request
  a_resp_has_entry: assert property (@(posedge clk) disable iff (reset)
    axil_resp_valid |-> head_valid);

endmodule

// File: verilog/resp_tracker_fifo.sv
module resp_tracker_fifo #(
  parameter int id_width        = 4,
  parameter int max_outstanding = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                push,
  input  logic [id_width-1:0] push_id,
  input  logic                push_last,
  output logic                room,
  input  logic                pop,
  output logic                head_valid,
  output logic [id_width-1:0] head_id,
  output logic                head_last
);

  localparam int ptr_width = $clog2(max_outstanding);
  localparam int cnt_width = $clog2(max_outstanding + 1);

  logic [id_width-1:0]  id_mem [max_outstanding];
  logic                 last_mem [max_outstanding];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;

  // Pointer step, wraps at depth so any depth works
  function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(max_outstanding - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // --------------------
  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      id_mem[wr_ptr]   <= push_id;
      last_mem[wr_ptr] <= push_last;
    end
  end

  // No bypass, a new entry shows up one edge after push
  assign room       = (count != cnt_width'(max_outstanding));
  assign head_valid = (count != '0);
  assign head_id    = id_mem[rd_ptr];
  assign head_last  = last_mem[rd_ptr];

  a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> room);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> head_valid);

endmodule

// File: verilog/beat_addr_gen.sv
module beat_addr_gen import axi_proto_pkg::*; #(
  parameter int addr_width = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [addr_width-1:0]     start_addr,
  input  logic [axi_len_width-1:0]  len,
  input  logic [axi_size_width-1:0] size,
  input  axi_burst_t                burst,
  input  logic                      beat_fire,
  input  logic                      clear,
  output logic [addr_width-1:0]     beat_addr,
  output logic                      is_last
);

  logic [axi_len_width-1:0] count;
  logic [addr_width-1:0]    incr_addr;
  logic [addr_width-1:0]    wrap_mask;

  // --------------------
  // Beat counter
  // clear wins, it lands on the same edge as the last beat
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count <= '0;
    end else if (beat_fire) begin
      count <= count + 1'b1;
    end
  end

  assign is_last = (count == len);

  // --------------------
  // Address of the current beat
  assign incr_addr = start_addr + (addr_width'(count) << size);

  // Wrap window is (len+1) beats of 2^size bytes
  assign wrap_mask = ((addr_width'(len) + 1'b1) << size) - 1'b1;

  always_comb begin
    case (burst)
      burst_incr: beat_addr = incr_addr;
      // Upper bits from the start, low bits wrap inside the window
      burst_wrap: beat_addr = (start_addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default:    beat_addr = start_addr;
    endcase
  end

  // No extra beat between the last one and the counter clearing
  a_no_beat_past_len: assert property (@(posedge clk) disable iff (reset)
    beat_fire |-> count <= len);

endmodule

// File: verilog/axi_req_slice.sv
module axi_req_slice import axi_proto_pkg::*; #(
  parameter int addr_width = 16,
  parameter int id_width   = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [addr_width-1:0]     req_addr,
  input  logic [id_width-1:0]       req_id,
  input  logic [axi_len_width-1:0]  req_len,
  input  logic [axi_size_width-1:0] req_size,
  input  axi_burst_t                req_burst,
  input  logic [axi_prot_width-1:0] req_prot,
  input  logic                      req_valid,
  output logic                      req_ready,
  input  logic                      pop,
  output logic                      hold_valid,
  output logic [addr_width-1:0]     hold_addr,
  output logic [id_width-1:0]       hold_id,
  output logic [axi_len_width-1:0]  hold_len,
  output logic [axi_size_width-1:0] hold_size,
  output axi_burst_t                hold_burst,
  output logic [axi_prot_width-1:0] hold_prot
);

  logic push;

  // Free when empty, or when the held burst retires this cycle
  assign req_ready = !hold_valid || pop;
  assign push = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      hold_valid <= 1'b0;
    end else if (push) begin
      hold_valid <= 1'b1;
    end else if (pop) begin
      hold_valid <= 1'b0;
    end
  end

  // Payload only moves on capture
  always_ff @(posedge clk) begin
    if (push) begin
      hold_addr  <= req_addr;
      hold_id    <= req_id;
      hold_len   <= req_len;
      hold_size  <= req_size;
      hold_burst <= req_burst;
      hold_prot  <= req_prot;
    end
  end

  // Reserved burst type is outside what the unroller supports
  a_no_reserved_burst: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> req_burst != burst_reserved);

endmodule

// File: verilog/bridge_ctrl_pkg.sv
package bridge_ctrl_pkg;

  // Burst controller states
  typedef enum logic [1:0] {
    // No burst held in the request slice
    st_idle  = 2'b00,
    // Burst held, beats may go out
    st_issue = 2'b01,
    // Burst held but the response tracker is full
    st_stall = 2'b10
  } ctrl_state_t;

endpackage

// File: verilog/axi_proto_pkg.sv
package axi_proto_pkg;

  // --------------------
  // Fixed AXI field widths
  localparam int axi_len_width  = 8;
  localparam int axi_size_width = 3;
  localparam int axi_prot_width = 3;

  // --------------------
  // Burst type as carried on AxBURST
  typedef enum logic [1:0] {
    burst_fixed    = 2'b00,
    burst_incr     = 2'b01,
    burst_wrap     = 2'b10,
    // Not defined by the protocol, never expected on the bus
    burst_reserved = 2'b11
  } axi_burst_t;

  // Response code on BRESP and RRESP
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_t;

endpackage
